/* rtl/execPkg.sv */
`default_nettype none

package execPkg;

	localparam int DataWidth = 32;

	// One shift-add step per multiplier bit
	localparam int MulCycles = DataWidth;
	localparam int MulCountWidth = $clog2(MulCycles + 1);

	typedef logic [DataWidth-1:0] word_t;

	// Single-precision encoding of 1.0
	localparam word_t FloatOne = 32'h3F80_0000;

	typedef enum logic [4:0] {
		opSll = 5'd0,
		opSrl = 5'd1,
		opSra = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opOr  = 5'd5,
		opAnd = 5'd6,
		opXor = 5'd7,
		opSeq = 5'd8,
		opSne = 5'd9,
		opSlt = 5'd10,
		opSgt = 5'd11,
		opSle = 5'd12,
		opSge = 5'd13,
		opLhi = 5'd14,
		opFeq = 5'd15,
		opFne = 5'd16,
		opFlt = 5'd17,
		opFgt = 5'd18,
		opFle = 5'd19,
		opFge = 5'd20,
		opMul = 5'd21
	} execOp_t;

	typedef enum logic [1:0] {
		fwdReg   = 2'd0,
		fwdExMem = 2'd1,
		fwdMemWb = 2'd2
	} fwdSel_t;

endpackage

`default_nettype wire

/* rtl/stageIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface stageIf;
	import execPkg::*;

	logic valid;
	logic ready;
	execOp_t op;
	word_t a;
	word_t b;

	modport source (
		output valid,
		output op,
		output a,
		output b,
		input ready
	);

	modport sink (
		input valid,
		input op,
		input a,
		input b,
		output ready
	);
endinterface

`default_nettype wire

/* rtl/operandSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input execPkg::execOp_t inOp,
	input execPkg::word_t inRegA,
	input execPkg::word_t inRegB,
	input execPkg::word_t inExMem,
	input execPkg::word_t inMemWb,
	input execPkg::fwdSel_t inSelA,
	input execPkg::fwdSel_t inSelB,
	input logic inUseImm,
	stageIf.source opOut
);
	import execPkg::*;

	logic entryValid;
	logic accept;
	execOp_t opReg;
	word_t aReg;
	word_t bReg;
	word_t selA;
	word_t selB;

	function automatic word_t pickSource(
		input fwdSel_t sel,
		input word_t regVal,
		input word_t exMemVal,
		input word_t memWbVal
	);
		case (sel)
			fwdExMem: return exMemVal;
			fwdMemWb: return memWbVal;
			default: return regVal;
		endcase
	endfunction

	// Immediate source bypasses forwarding on B
	assign selA = pickSource(inSelA, inRegA, inExMem, inMemWb);
	assign selB = inUseImm ? inRegB : pickSource(inSelB, inRegB, inExMem, inMemWb);

	// Room when empty or draining this cycle
	assign inReady = !entryValid || opOut.ready;
	assign accept = inValid && inReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			entryValid <= 1'b0;
		end else if (accept) begin
			entryValid <= 1'b1;
		end else if (opOut.ready) begin
			entryValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			opReg <= inOp;
			aReg <= selA;
			bReg <= selB;
		end
	end

	assign opOut.valid = entryValid;
	assign opOut.op = opReg;
	assign opOut.a = aReg;
	assign opOut.b = bReg;
endmodule

`default_nettype wire

/* rtl/integerAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module integerAlu (
	input execPkg::execOp_t op,
	input execPkg::word_t a,
	input execPkg::word_t b,
	output execPkg::word_t result
);
	import execPkg::*;

	logic isEq;
	logic isLt;
	logic isGt;
	word_t lhiValue;

	function automatic word_t setFlag(input logic flag);
		return word_t'(flag);
	endfunction

	function automatic word_t floatFlag(input logic flag);
		return flag ? FloatOne : '0;
	endfunction

	// Compares are unsigned for both the set and float forms
	assign isEq = (a == b);
	assign isLt = (a < b);
	assign isGt = (a > b);

	// Low half of B moved to the upper half
	assign lhiValue = {b[DataWidth/2-1:0], {(DataWidth/2){1'b0}}};

	always_comb begin
		case (op)
			// Full B as the amount, so large shifts empty the word
			opSll: result = a << b;
			opSrl: result = a >> b;
			opSra: result = $signed(a) >>> b;
			opAdd: result = a + b;
			opSub: result = a - b;
			opOr: result = a | b;
			opAnd: result = a & b;
			opXor: result = a ^ b;
			opSeq: result = setFlag(isEq);
			opSne: result = setFlag(!isEq);
			opSlt: result = setFlag(isLt);
			opSgt: result = setFlag(isGt);
			opSle: result = setFlag(!isGt);
			opSge: result = setFlag(!isLt);
			opLhi: result = lhiValue;
			opFeq: result = floatFlag(isEq);
			opFne: result = floatFlag(!isEq);
			opFlt: result = floatFlag(isLt);
			opFgt: result = floatFlag(isGt);
			opFle: result = floatFlag(!isGt);
			opFge: result = floatFlag(!isLt);
			// opMul is served by the multiplier
			default: result = '0;
		endcase
	end
endmodule

`default_nettype wire

/* rtl/shiftAddMultiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module shiftAddMultiplier (
	input logic clock,
	input logic rstN,
	input logic start,
	input execPkg::word_t a,
	input execPkg::word_t b,
	output logic busy,
	output logic done,
	output execPkg::word_t product
);
	import execPkg::*;

	logic [MulCountWidth-1:0] stepsLeft;
	logic loadOperands;
	word_t multiplicand;
	word_t multiplier;
	word_t accum;

	// Start is ignored while a product is in progress
	assign loadOperands = start && !busy;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			done <= 1'b0;
			stepsLeft <= '0;
		end else begin
			done <= 1'b0;
			if (busy) begin
				stepsLeft <= stepsLeft - 1'b1;
				if (stepsLeft == MulCountWidth'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end else if (loadOperands) begin
				busy <= 1'b1;
				stepsLeft <= MulCountWidth'(MulCycles);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (loadOperands) begin
			multiplicand <= a;
			multiplier <= b;
			accum <= '0;
		end else if (busy) begin
			// Add the shifted multiplicand for each set multiplier bit
			if (multiplier[0]) begin
				accum <= accum + multiplicand;
			end
			multiplicand <= multiplicand << 1;
			multiplier <= multiplier >> 1;
		end
	end

	// Holds the low word until the next start
	assign product = accum;
endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic clock,
	input logic rstN,
	stageIf.sink opIn,
	output logic outValid,
	input logic outReady,
	output execPkg::word_t outResult,
	output logic outBranch
);
	import execPkg::*;

	logic isMul;
	logic canLoad;
	logic accept;
	logic mulStart;
	logic mulBusy;
	logic mulDone;
	logic mulIssued;
	logic mulFinished;
	word_t aluResult;
	word_t mulProduct;
	word_t resultReg;

	integerAlu alu (
		.op     (opIn.op),
		.a      (opIn.a),
		.b      (opIn.b),
		.result (aluResult)
	);

	shiftAddMultiplier mul (
		.clock   (clock),
		.rstN    (rstN),
		.start   (mulStart),
		.a       (opIn.a),
		.b       (opIn.b),
		.busy    (mulBusy),
		.done    (mulDone),
		.product (mulProduct)
	);

	assign isMul = (opIn.op == opMul);
	assign canLoad = !outValid || outReady;

	// A multiply is taken only once its product is ready
	assign opIn.ready = canLoad && (!isMul || mulDone || mulFinished);
	assign accept = opIn.valid && opIn.ready;
	assign mulStart = opIn.valid && isMul && !mulIssued && !mulBusy;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			mulIssued <= 1'b0;
			mulFinished <= 1'b0;
		end else begin
			if (accept) begin
				outValid <= 1'b1;
			end else if (outReady) begin
				outValid <= 1'b0;
			end
			if (accept) begin
				mulIssued <= 1'b0;
				mulFinished <= 1'b0;
			end else begin
				if (mulStart) begin
					mulIssued <= 1'b1;
				end
				// Done may arrive while the result register is still full
				if (mulDone) begin
					mulFinished <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			resultReg <= isMul ? mulProduct : aluResult;
		end
	end

	assign outResult = resultReg;
	assign outBranch = resultReg[0];
endmodule

`default_nettype wire

/* rtl/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input execPkg::execOp_t inOp,
	input execPkg::word_t inRegA,
	input execPkg::word_t inRegB,
	input execPkg::word_t inExMem,
	input execPkg::word_t inMemWb,
	input execPkg::fwdSel_t inSelA,
	input execPkg::fwdSel_t inSelB,
	input logic inUseImm,
	output logic outValid,
	input logic outReady,
	output execPkg::word_t outResult,
	output logic outBranch
);

	// Operand register to execute stage
	stageIf opBus ();

	operandSelect opSelect (
		.clock    (clock),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inOp     (inOp),
		.inRegA   (inRegA),
		.inRegB   (inRegB),
		.inExMem  (inExMem),
		.inMemWb  (inMemWb),
		.inSelA   (inSelA),
		.inSelB   (inSelB),
		.inUseImm (inUseImm),
		.opOut    (opBus)
	);

	executeStage exStage (
		.clock     (clock),
		.rstN      (rstN),
		.opIn      (opBus),
		.outValid  (outValid),
		.outReady  (outReady),
		.outResult (outResult),
		.outBranch (outBranch)
	);
endmodule

`default_nettype wire

/* sim/executeUnit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit_checker (
	input logic clock,
	input logic rstN,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input execPkg::word_t outResult
);

	int failCount = 0;
	logic [1:0] inFlight;
	logic inFire;
	logic outFire;

	assign inFire = inValid && inReady;
	assign outFire = outValid && outReady;

	// Operations accepted but not yet delivered
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			inFlight <= '0;
		end else begin
			inFlight <= inFlight + 2'(inFire) - 2'(outFire);
		end
	end

	resetQuiet: assert property (@(posedge clock) !rstN |-> !outValid && inReady ##1 !outValid)
		else begin
			failCount++;
			$error("outValid high or inReady low around reset");
		end

	holdWhileStalled: assert property (@(posedge clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outResult))
		else begin
			failCount++;
			$error("stalled result was dropped or changed");
		end

	readyWhenEmpty: assert property (@(posedge clock) disable iff (!rstN)
		inFlight == 2'd0 |-> inReady)
		else begin
			failCount++;
			$error("inReady low while the pipeline is empty");
		end

	// Entry and result register both full
	stallWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		inFlight == 2'd2 && !outReady |-> !inReady)
		else begin
			failCount++;
			$error("inReady high with two operations held");
		end

	atMostTwo: assert property (@(posedge clock) disable iff (!rstN) inFlight != 2'd3)
		else begin
			failCount++;
			$error("more than two operations in flight");
		end
endmodule

bind executeUnit executeUnit_checker handshakeCheck (
	.clock     (clock),
	.rstN      (rstN),
	.inValid   (inValid),
	.inReady   (inReady),
	.outValid  (outValid),
	.outReady  (outReady),
	.outResult (outResult)
);

`default_nettype wire

/* sim/executeUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnitTb;
	import execPkg::*;

	localparam int ShiftBits = $clog2(DataWidth);
	localparam int NumRandom = 100;
	localparam int NumOps = 18 + 36 + 36 + 6 + NumRandom;
	localparam int TimeoutCycles = NumOps * (MulCycles + 4) + 50;

	logic clock = 1'b0;
	logic rstN;
	logic inValid;
	logic inReady;
	execOp_t inOp;
	word_t inRegA;
	word_t inRegB;
	word_t inExMem;
	word_t inMemWb;
	fwdSel_t inSelA;
	fwdSel_t inSelB;
	logic inUseImm;
	logic outValid;
	logic outReady;
	word_t outResult;
	logic outBranch;

	word_t expected[$];
	int scoreErrors = 0;
	int timeoutErrors = 0;
	int cycleCount = 0;

	executeUnit dut (.*);

	always #50 clock = ~clock;

	function automatic word_t chooseSource(input fwdSel_t sel, input word_t regVal,
			input word_t exMemVal, input word_t memWbVal);
		if (sel == fwdExMem) return exMemVal;
		if (sel == fwdMemWb) return memWbVal;
		return regVal;
	endfunction

	// Expected result straight from the operation definitions
	function automatic word_t modelResult(input execOp_t op, input word_t a, input word_t b);
		logic [2*DataWidth-1:0] fullProduct;
		logic signed [DataWidth-1:0] arith;
		logic bigShift;
		fullProduct = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
		bigShift = (b >= DataWidth);
		arith = $signed(a) >>> b[ShiftBits-1:0];
		case (op)
			opSll: return bigShift ? '0 : a << b[ShiftBits-1:0];
			opSrl: return bigShift ? '0 : a >> b[ShiftBits-1:0];
			opSra: return bigShift ? {DataWidth{a[DataWidth-1]}} : arith;
			opAdd: return a + b;
			opSub: return a - b;
			opOr: return a | b;
			opAnd: return a & b;
			opXor: return a ^ b;
			opSeq: return word_t'(a == b);
			opSne: return word_t'(a != b);
			opSlt: return word_t'(a < b);
			opSgt: return word_t'(a > b);
			opSle: return word_t'(a <= b);
			opSge: return word_t'(a >= b);
			opLhi: return b << (DataWidth / 2);
			opFeq: return (a == b) ? FloatOne : '0;
			opFne: return (a != b) ? FloatOne : '0;
			opFlt: return (a < b) ? FloatOne : '0;
			opFgt: return (a > b) ? FloatOne : '0;
			opFle: return (a <= b) ? FloatOne : '0;
			opFge: return (a >= b) ? FloatOne : '0;
			opMul: return fullProduct[DataWidth-1:0];
			default: return '0;
		endcase
	endfunction

	task automatic nextCycle();
		@(posedge clock);
		#10;
		outReady = ($urandom_range(0, 3) != 0);
	endtask

	task automatic sendOp(input execOp_t op, input word_t regA, input word_t regB,
			input word_t exMem, input word_t memWb, input fwdSel_t selA, input fwdSel_t selB,
			input logic useImm);
		word_t opA;
		word_t opB;
		logic taken;
		opA = chooseSource(selA, regA, exMem, memWb);
		opB = useImm ? regB : chooseSource(selB, regB, exMem, memWb);
		inValid = 1'b1;
		inOp = op;
		inRegA = regA;
		inRegB = regB;
		inExMem = exMem;
		inMemWb = memWb;
		inSelA = selA;
		inSelB = selB;
		inUseImm = useImm;
		taken = 1'b0;
		while (!taken) begin
			#1;
			// inReady is settled here and holds until the edge
			if (inReady) begin
				expected.push_back(modelResult(op, opA, opB));
				taken = 1'b1;
			end
			nextCycle();
		end
		inValid = 1'b0;
	endtask

	task automatic sendSimple(input execOp_t op, input word_t a, input word_t b);
		sendOp(op, a, b, $urandom, $urandom, fwdReg, fwdReg, 1'($urandom_range(0, 1)));
	endtask

	task automatic printTotals();
		$display("Errors: scoreboard %0d, checker %0d, timeout %0d",
			scoreErrors, dut.handshakeCheck.failCount, timeoutErrors);
	endtask

	// Output side is stable at the falling edge
	always @(negedge clock) begin
		word_t want;
		if (rstN && outValid && outReady) begin
			queueNotEmpty: assert (expected.size() != 0) else begin
				scoreErrors++;
				$display("Output transfer at %0t with no operation outstanding", $time);
			end
			if (expected.size() != 0) begin
				want = expected.pop_front();
				resultCheck: assert (outResult === want) else begin
					scoreErrors++;
					$display("mismatch at %0t: outResult = %h, expected %h", $time,
						outResult, want);
				end
				branchCheck: assert (outBranch === want[0]) else begin
					scoreErrors++;
					$display("mismatch at %0t: outBranch = %b, expected %b", $time, outBranch,
						want[0]);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles) begin
			timeoutErrors++;
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			printTotals();
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		word_t lo;
		word_t hi;
		execOp_t op;
		void'($urandom(32'he252));
		rstN = 1'b1;
		inValid = 1'b0;
		inOp = opAdd;
		inRegA = '0;
		inRegB = '0;
		inExMem = '0;
		inMemWb = '0;
		inSelA = fwdReg;
		inSelB = fwdReg;
		inUseImm = 1'b0;
		outReady = 1'b1;
		// Clean falling edge for the asynchronous reset
		#5 rstN = 1'b0;
		repeat (3) @(posedge clock);
		#10 rstN = 1'b1;

		for (int selA = 0; selA < 3; selA++) begin
			for (int selB = 0; selB < 3; selB++) begin
				for (int imm = 0; imm < 2; imm++) begin
					sendOp(opAdd, $urandom, $urandom, $urandom, $urandom, fwdSel_t'(selA),
						fwdSel_t'(selB), imm[0]);
				end
			end
		end

		for (int code = 0; code <= int'(opLhi); code++) begin
			op = execOp_t'(code);
			if (op >= opSeq && op <= opSge) continue;
			sendSimple(op, $urandom, $urandom);
			sendSimple(op, $urandom, DataWidth);
			sendSimple(op, $urandom, $urandom | 32'h20);
			sendSimple(op, $urandom, $urandom_range(0, DataWidth - 1));
		end

		for (int code = int'(opSeq); code <= int'(opFge); code++) begin
			op = execOp_t'(code);
			if (op == opLhi) continue;
			lo = $urandom >> 1;
			hi = lo + ($urandom >> 1) + 1;
			sendSimple(op, lo, lo);
			sendSimple(op, lo, hi);
			sendSimple(op, hi, lo);
		end

		sendSimple(opMul, '0, $urandom);
		sendSimple(opMul, $urandom, '0);
		sendSimple(opMul, '1, '1);
		sendSimple(opMul, '1, $urandom);
		sendSimple(opMul, $urandom, $urandom);
		sendSimple(opMul, $urandom, $urandom);

		repeat (NumRandom) begin
			if ($urandom_range(0, 3) == 0) nextCycle();
			sendOp(execOp_t'($urandom_range(0, int'(opMul))), $urandom, $urandom, $urandom,
				$urandom, fwdSel_t'($urandom_range(0, 2)), fwdSel_t'($urandom_range(0, 2)),
				1'($urandom_range(0, 1)));
		end

		while (expected.size() != 0) nextCycle();
		repeat (4) nextCycle();
		#1;

		// Nothing left in either register once every result is out
		pipelineIdle: assert (!outValid && inReady) else begin
			scoreErrors++;
			$display("Pipeline still holds an operation after the last result was delivered");
		end

		printTotals();
		if (scoreErrors == 0 && dut.handshakeCheck.failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

/* filelist.f */
rtl/execPkg.sv
rtl/stageIf.sv
rtl/operandSelect.sv
rtl/integerAlu.sv
rtl/shiftAddMultiplier.sv
rtl/executeStage.sv
rtl/executeUnit.sv
sim/executeUnit_checker.sv
sim/executeUnitTb.sv
